/* verilog/sensor_hub_pkg.sv */
package sensor_hub_pkg;

	localparam int num_streams = 8;
	localparam int sample_w = 16;
	localparam int tag_w = 8;
	localparam int frame_w = 2 * tag_w + sample_w;

	typedef logic [2:0] stream_id_t;
	typedef logic [num_streams-1:0] stream_mask_t;
	typedef logic [sample_w-1:0] sample_t;
	typedef logic [tag_w-1:0] tag_t;

	// Tag in bits 7:0, sample in bits 23:8, tag again in bits 31:24.
	typedef logic [frame_w-1:0] frame_t;

	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_WAIT,
		REQ_STORE
	} req_state_t;

	typedef enum logic {
		SW_IDLE,
		SW_HOLD
	} sw_state_t;

	// First set bit of mask after position last, wrapping around.
	function automatic stream_id_t rr_next(stream_mask_t mask, stream_id_t last);
		stream_id_t pick;
		stream_id_t cand;
		pick = last;
		for (int i = num_streams; i >= 1; i--) begin
			cand = stream_id_t'(last + i); // Wraps on the 3-bit stream number.
			if (mask[cand])
				pick = cand;
		end
		return pick;
	endfunction

endpackage

/* verilog/stream_fifo_if.sv */
`timescale 1ns/100ps

interface stream_fifo_if;
	import sensor_hub_pkg::*;

	logic wr_en;
	stream_id_t wr_stream;
	frame_t wr_frame;

	stream_mask_t full;
	stream_mask_t empty;

	logic rd_en;
	stream_id_t rd_stream;
	frame_t rd_frame; // Head of the FIFO picked by rd_stream.

	modport producer (
		output wr_en, wr_stream, wr_frame,
		input full
	);

	modport buffer (
		input wr_en, wr_stream, wr_frame,
		input rd_en, rd_stream,
		output full, empty, rd_frame
	);

	modport consumer (
		output rd_en, rd_stream,
		input empty, rd_frame
	);

endinterface

/* verilog/frame_fifo.sv */
`timescale 1ns/100ps

module frame_fifo #(
	parameter int fifo_depth = 4
) (
	input logic clock,
	input logic rst_n,
	input logic push,
	input logic pop,
	input sensor_hub_pkg::frame_t din,
	output sensor_hub_pkg::frame_t dout,
	output logic full,
	output logic empty
);
	import sensor_hub_pkg::*;

	localparam int ptr_w = $clog2(fifo_depth);

	frame_t mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two, so it wraps.
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			unique case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	assign dout = mem[rd_ptr]; // Head shows without a read cycle.
	assign full = (count == (ptr_w + 1)'(fifo_depth));
	assign empty = (count == '0);

endmodule

/* verilog/stream_buffer_bank.sv */
`timescale 1ns/100ps

module stream_buffer_bank #(
	parameter int fifo_depth = 4
) (
	input logic clock,
	input logic rst_n,
	stream_fifo_if.buffer fifo
);
	import sensor_hub_pkg::*;

	stream_mask_t push;
	stream_mask_t pop;
	stream_mask_t full_mask;
	stream_mask_t empty_mask;
	frame_t heads [num_streams];

	for (genvar g = 0; g < num_streams; g++) begin : g_stream
		assign push[g] = fifo.wr_en && (fifo.wr_stream == stream_id_t'(g));
		assign pop[g] = fifo.rd_en && (fifo.rd_stream == stream_id_t'(g));

		frame_fifo #(
			.fifo_depth(fifo_depth)
		) u_frame_fifo (
			.clock(clock),
			.rst_n(rst_n),
			.push(push[g]),
			.pop(pop[g]),
			.din(fifo.wr_frame),
			.dout(heads[g]),
			.full(full_mask[g]),
			.empty(empty_mask[g])
		);
	end

	assign fifo.full = full_mask;
	assign fifo.empty = empty_mask;
	assign fifo.rd_frame = heads[fifo.rd_stream];

endmodule

/* verilog/sensor_requester.sv */
`timescale 1ns/100ps

module sensor_requester (
	input logic clock,
	input logic rst_n,
	stream_fifo_if.producer fifo,
	input sensor_hub_pkg::stream_mask_t selected_streams,
	input logic access_datastreams,
	input logic command_from_app,
	output sensor_hub_pkg::stream_mask_t sensor_request,
	input logic sensor_valid,
	input sensor_hub_pkg::sample_t sensor_sample,
	output logic sample_dropped
);
	import sensor_hub_pkg::*;

	req_state_t state;
	stream_mask_t active;
	stream_id_t next_stream;
	stream_id_t cur_stream;
	sample_t sample_q;
	logic enable;
	logic store;

	assign enable = access_datastreams & command_from_app;
	assign active = selected_streams & {num_streams{enable}};

	// The stream being served is also the round-robin start point.
	assign next_stream = rr_next(active, cur_stream);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= REQ_IDLE;
			cur_stream <= stream_id_t'(num_streams - 1); // Stream 0 is polled first.
		end else begin
			unique case (state)
				REQ_IDLE: begin
					if (|active) begin
						cur_stream <= next_stream;
						state <= REQ_WAIT;
					end
				end
				REQ_WAIT: begin
					if (sensor_valid)
						state <= REQ_STORE;
				end
				REQ_STORE: begin
					state <= REQ_IDLE;
				end
				default: begin
					state <= REQ_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == REQ_WAIT && sensor_valid)
			sample_q <= sensor_sample; // Latency is set by the sensor.
	end

	always_comb begin
		sensor_request = '0;
		if (state == REQ_IDLE && |active)
			sensor_request[next_stream] = 1'b1; // One-cycle one-hot request.
	end

	assign store = (state == REQ_STORE);

	// A full FIFO loses the sample.
	assign fifo.wr_en = store & ~fifo.full[cur_stream];
	assign sample_dropped = store & fifo.full[cur_stream];

	assign fifo.wr_stream = cur_stream;
	assign fifo.wr_frame = {tag_t'(cur_stream), sample_q, tag_t'(cur_stream)};

endmodule

/* verilog/master_switch.sv */
`timescale 1ns/100ps

module master_switch (
	input logic clock,
	input logic rst_n,
	stream_fifo_if.consumer fifo,
	input logic ready_to_send,
	input logic packet_sent,
	output sensor_hub_pkg::stream_id_t mux_select,
	output logic select_ready,
	output logic packet_valid,
	output sensor_hub_pkg::frame_t packet_data,
	output logic sending_flag
);
	import sensor_hub_pkg::*;

	sw_state_t state;
	stream_id_t served_stream;
	stream_id_t next_stream;
	frame_t hold_frame;
	logic any_data;
	logic start;

	assign any_data = (fifo.empty != {num_streams{1'b1}});
	assign next_stream = rr_next(~fifo.empty, served_stream);
	assign start = (state == SW_IDLE) && ready_to_send && any_data;

	// The pop and the search happen in the same cycle.
	assign fifo.rd_en = start;
	assign fifo.rd_stream = next_stream;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= SW_IDLE;
			served_stream <= '0;
		end else begin
			unique case (state)
				SW_IDLE: begin
					if (start) begin
						served_stream <= next_stream;
						state <= SW_HOLD;
					end
				end
				SW_HOLD: begin
					if (packet_sent)
						state <= SW_IDLE;
				end
				default: begin
					state <= SW_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			hold_frame <= fifo.rd_frame; // Head before the pop takes effect.
	end

	assign packet_valid = (state == SW_HOLD);
	assign select_ready = (state == SW_HOLD);
	assign packet_data = hold_frame;
	assign mux_select = served_stream;
	assign sending_flag = any_data;

endmodule

/* verilog/sensor_hub_top.sv */
`timescale 1ns/100ps

module sensor_hub_top #(
	parameter int fifo_depth = 4
) (
	input logic clock,
	input logic rst_n,
	input sensor_hub_pkg::stream_mask_t selected_streams,
	input logic access_datastreams,
	input logic command_from_app,
	output sensor_hub_pkg::stream_mask_t sensor_request,
	input logic sensor_valid,
	input sensor_hub_pkg::sample_t sensor_sample,
	output logic sample_dropped,
	input logic ready_to_send,
	input logic packet_sent,
	output sensor_hub_pkg::stream_id_t mux_select,
	output logic select_ready,
	output logic packet_valid,
	output sensor_hub_pkg::frame_t packet_data,
	output logic sending_flag
);

	stream_fifo_if u_fifo_if ();

	sensor_requester u_sensor_requester (
		.clock(clock),
		.rst_n(rst_n),
		.fifo(u_fifo_if.producer),
		.selected_streams(selected_streams),
		.access_datastreams(access_datastreams),
		.command_from_app(command_from_app),
		.sensor_request(sensor_request),
		.sensor_valid(sensor_valid),
		.sensor_sample(sensor_sample),
		.sample_dropped(sample_dropped)
	);

	stream_buffer_bank #(
		.fifo_depth(fifo_depth)
	) u_stream_buffer_bank (
		.clock(clock),
		.rst_n(rst_n),
		.fifo(u_fifo_if.buffer)
	);

	master_switch u_master_switch (
		.clock(clock),
		.rst_n(rst_n),
		.fifo(u_fifo_if.consumer),
		.ready_to_send(ready_to_send),
		.packet_sent(packet_sent),
		.mux_select(mux_select),
		.select_ready(select_ready),
		.packet_valid(packet_valid),
		.packet_data(packet_data),
		.sending_flag(sending_flag)
	);

endmodule

/* verif/sensor_hub_tb.sv */
`timescale 1ns/100ps

module sensor_hub_tb;
	import sensor_hub_pkg::*;

	localparam int fifo_depth = 4;
	localparam int q_size = 8;
	localparam int reset_cycles = 2;
	localparam int off_cycles = 60;
	localparam int mix_cycles = 400;
	localparam int fill_cycles = 320;
	localparam int drain_cycles = 300;
	localparam int planned_cycles = reset_cycles + off_cycles + mix_cycles + fill_cycles
		+ drain_cycles;
	localparam int cycle_limit = 2 * planned_cycles;

	localparam int mode_off = 0;
	localparam int mode_mix = 1;
	localparam int mode_fill = 2;
	localparam int mode_drain = 3;

	logic clock;
	logic rst_n;
	stream_mask_t selected_streams;
	logic access_datastreams;
	logic command_from_app;
	stream_mask_t sensor_request;
	logic sensor_valid;
	sample_t sensor_sample;
	logic sample_dropped;
	logic ready_to_send;
	logic packet_sent;
	stream_id_t mux_select;
	logic select_ready;
	logic packet_valid;
	frame_t packet_data;
	logic sending_flag;

	integer seed;
	int cycle_count;
	int answer_wait; // Cycles until the sensor model answers.
	int drop_count;
	int frames_seen;

	// Reference queues, one ring per stream.
	sample_t q_mem [num_streams][q_size];
	int q_head [num_streams];
	int q_count [num_streams];

	logic outstanding;
	logic store_due;
	stream_id_t req_stream;
	stream_id_t store_stream;
	sample_t store_sample;
	logic pv_prev;
	logic hold_next; // Whether the switch should hold a frame at the next check.
	frame_t held_frame;
	stream_id_t held_sel;

	sensor_hub_top #(
		.fifo_depth(fifo_depth)
	) u_sensor_hub_top (
		.clock(clock),
		.rst_n(rst_n),
		.selected_streams(selected_streams),
		.access_datastreams(access_datastreams),
		.command_from_app(command_from_app),
		.sensor_request(sensor_request),
		.sensor_valid(sensor_valid),
		.sensor_sample(sensor_sample),
		.sample_dropped(sample_dropped),
		.ready_to_send(ready_to_send),
		.packet_sent(packet_sent),
		.mux_select(mux_select),
		.select_ready(select_ready),
		.packet_valid(packet_valid),
		.packet_data(packet_data),
		.sending_flag(sending_flag)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("ERR @ %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	// Inputs change 2 ns after the rising edge.
	task automatic drive_cycle(input int mode);
		logic [1:0] ctrl;
		@(posedge clock);
		#2;
		sensor_valid = 1'b0;
		if (answer_wait > 0) begin
			answer_wait = answer_wait - 1;
			if (answer_wait == 0) begin
				sensor_valid = 1'b1;
				sensor_sample = sample_t'($random(seed));
			end
		end
		packet_sent = packet_valid && ($random(seed) & 1);
		case (mode)
			mode_off: begin
				ctrl = 2'($random(seed));
				if (ctrl == 2'b11)
					ctrl = 2'b01; // At least one control stays low.
				access_datastreams = ctrl[0];
				command_from_app = ctrl[1];
				selected_streams = stream_mask_t'($random(seed));
				ready_to_send = 1'b1;
			end
			mode_mix: begin
				if (($random(seed) & 15) == 0)
					selected_streams = stream_mask_t'($random(seed));
				access_datastreams = ($random(seed) & 15) != 0;
				command_from_app = ($random(seed) & 15) != 0;
				ready_to_send = ($random(seed) & 3) != 0;
			end
			mode_fill: begin
				selected_streams = '1;
				access_datastreams = 1'b1;
				command_from_app = 1'b1;
				ready_to_send = 1'b0;
			end
			default: begin
				access_datastreams = 1'b0;
				command_from_app = 1'b0;
				ready_to_send = 1'b1;
			end
		endcase
	endtask

	task automatic observe_cycle();
		frame_t expected;
		stream_mask_t allowed;
		logic [7:0] tag;
		logic drop_expected;
		logic any_queued;
		int slot;
		check_eq(packet_valid, hold_next, "packet_valid against the switch model");
		check_eq(select_ready, hold_next, "select_ready against the switch model");
		if (packet_valid && !pv_prev) begin
			check_eq(q_count[mux_select] != 0, 1, "frame with no sample queued for its stream");
			tag = {5'b0, mux_select};
			expected = {tag, q_mem[mux_select][q_head[mux_select]], tag};
			check_eq(packet_data, expected, "frame data");
			q_head[mux_select] = (q_head[mux_select] + 1) % q_size;
			q_count[mux_select] = q_count[mux_select] - 1;
			held_frame = packet_data;
			held_sel = mux_select;
			frames_seen = frames_seen + 1;
		end else if (packet_valid) begin
			check_eq(packet_data, held_frame, "frame changed while held");
			check_eq(mux_select, held_sel, "mux_select changed while held");
		end
		pv_prev = packet_valid;

		if (!packet_valid) begin
			any_queued = 1'b0;
			for (int s = 0; s < num_streams; s++)
				any_queued = any_queued | (q_count[s] != 0);
			check_eq(sending_flag, any_queued, "sending_flag while the switch is idle");
			hold_next = ready_to_send && any_queued; // An idle switch pops when ready.
		end else begin
			hold_next = !packet_sent;
		end

		// The write lands one cycle after the sample.
		if (store_due) begin
			drop_expected = (q_count[store_stream] >= fifo_depth);
			check_eq(sample_dropped, drop_expected, "sample_dropped");
			if (drop_expected) begin
				drop_count = drop_count + 1;
			end else begin
				slot = (q_head[store_stream] + q_count[store_stream]) % q_size;
				q_mem[store_stream][slot] = store_sample;
				q_count[store_stream] = q_count[store_stream] + 1;
			end
			store_due = 1'b0;
			outstanding = 1'b0;
		end else begin
			check_eq(sample_dropped, 0, "sample_dropped outside a store");
		end
		if (sensor_valid) begin
			store_due = 1'b1;
			store_stream = req_stream;
			store_sample = sensor_sample;
		end

		allowed = (access_datastreams && command_from_app) ? selected_streams : '0;
		if (sensor_request != '0) begin
			check_eq(outstanding, 0, "request while another is outstanding");
			check_eq((sensor_request & (sensor_request - 1'b1)) == '0, 1,
				"request is not one-hot");
			check_eq(sensor_request & ~allowed, 0, "request for a stream that is not active");
			for (int s = 0; s < num_streams; s++) begin
				if (sensor_request[s])
					req_stream = stream_id_t'(s);
			end
			outstanding = 1'b1;
			answer_wait = 1 + ($random(seed) & 3); // Sensor latency of 1 to 4 cycles.
		end
	endtask

	initial begin
		forever begin
			@(negedge clock);
			if (rst_n)
				observe_cycle();
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped by the cycle limit.");
	end

	initial begin
		int drops_before;
		seed = 32'h9f86;
		rst_n = 1'b0;
		selected_streams = '0;
		access_datastreams = 1'b0;
		command_from_app = 1'b0;
		sensor_valid = 1'b0;
		sensor_sample = '0;
		ready_to_send = 1'b0;
		packet_sent = 1'b0;
		answer_wait = 0;
		drop_count = 0;
		frames_seen = 0;
		outstanding = 1'b0;
		store_due = 1'b0;
		req_stream = '0;
		store_stream = '0;
		store_sample = '0;
		pv_prev = 1'b0;
		hold_next = 1'b0;
		held_frame = '0;
		held_sel = '0;
		for (int s = 0; s < num_streams; s++) begin
			q_head[s] = 0;
			q_count[s] = 0;
		end

		repeat (reset_cycles) @(posedge clock);
		#1;
		check_eq(sensor_request, 0, "sensor_request in reset");
		check_eq(sample_dropped, 0, "sample_dropped in reset");
		check_eq(packet_valid, 0, "packet_valid in reset");
		check_eq(select_ready, 0, "select_ready in reset");
		check_eq(mux_select, 0, "mux_select in reset");
		check_eq(sending_flag, 0, "sending_flag in reset");
		#1 rst_n = 1'b1;

		repeat (off_cycles) drive_cycle(mode_off);
		repeat (mix_cycles) drive_cycle(mode_mix);

		drops_before = drop_count;
		repeat (fill_cycles) drive_cycle(mode_fill);
		for (int s = 0; s < num_streams; s++)
			check_eq(q_count[s], fifo_depth, "stream not filled while ready_to_send is low");
		check_eq(drop_count > drops_before, 1, "no sample dropped with full FIFOs");

		// Drain until nothing is queued, held or in flight.
		drive_cycle(mode_drain);
		while (sending_flag || packet_valid || outstanding || store_due || answer_wait != 0)
			drive_cycle(mode_drain);
		repeat (2) drive_cycle(mode_drain);

		for (int s = 0; s < num_streams; s++)
			check_eq(q_count[s], 0, "model queue not empty after the drain");
		check_eq(frames_seen > 0, 1, "no frame reached the outputs");
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* all.f */
verilog/sensor_hub_pkg.sv
verilog/stream_fifo_if.sv
verilog/frame_fifo.sv
verilog/stream_buffer_bank.sv
verilog/sensor_requester.sv
verilog/master_switch.sv
verilog/sensor_hub_top.sv
verif/sensor_hub_tb.sv

/* Bender.yml */
package:
  name: sensor_hub

sources:
  - files:
      - verilog/sensor_hub_pkg.sv
      - verilog/stream_fifo_if.sv
      - verilog/frame_fifo.sv
      - verilog/stream_buffer_bank.sv
      - verilog/sensor_requester.sv
      - verilog/master_switch.sv
      - verilog/sensor_hub_top.sv
  - target: test
    files:
      - verif/sensor_hub_tb.sv
